// File: source/cache_pkg.sv
// ----------------------------
// Cache geometry, width types, init state
// and the request and response structs
// ----------------------------
package cache_pkg;

    // Geometry
    localparam int unsigned NUM_SETS   = 16;
    localparam int unsigned NUM_WAYS   = 4;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WORD_BYTES = 4;
    localparam int unsigned TAG_BITS   = 8;

    typedef logic [$clog2(NUM_SETS)-1:0]   set_idx_t;
    typedef logic [TAG_BITS-1:0]           tag_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;
    typedef logic [NUM_WAYS-1:0]           way_vec_t;
    typedef logic [8*WORD_BYTES-1:0]       data_word_t;
    typedef logic [WORD_BYTES-1:0]         byte_en_t;

    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } init_state_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    typedef struct packed {
        set_idx_t  set;
        tag_t      tag;
        word_idx_t word;
    } lookup_req_t;

    typedef struct packed {
        set_idx_t   set;
        word_idx_t  word;
        data_word_t data;
        byte_en_t   be;
    } write_req_t;

    // One refill beat
    typedef struct packed {
        set_idx_t   set;
        way_vec_t   way;
        tag_t       tag;
        word_idx_t  word;
        data_word_t data;
    } refill_req_t;

    typedef struct packed {
        logic       hit;
        way_vec_t   hit_way;
        data_word_t rdata;
        way_vec_t   victim_way;
    } lookup_rsp_t;

endpackage

// File: source/sram_1rw.sv
// ----------------------------
// Single-port RAM, byte write enable
// ----------------------------
`timescale 1ns/1ps

module sram_1rw #(
    parameter  int unsigned DEPTH  = 16,
    parameter  int unsigned WIDTH  = 32,
    localparam int unsigned ADDR_W = $clog2(DEPTH),
    localparam int unsigned BE_W   = (WIDTH + 7) / 8
) (
    input  logic              clk_i,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WIDTH-1:0]  wdata_i,
    input  logic [BE_W-1:0]   be_i,
    output logic [WIDTH-1:0]  rdata_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    // Read returns the old contents on a write cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int i = 0; i < WIDTH; i++) begin
                    if (be_i[i / 8]) begin
                        mem_q[addr_i][i] <= wdata_i[i];
                    end
                end
            end
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// File: source/dir_init_fsm.sv
// ----------------------------
// Directory clear sweep after reset
// ----------------------------
`timescale 1ns/1ps

module dir_init_fsm (
    input  logic              clk_i,
    input  logic              rst_ni,
    output logic              ready_o,
    output cache_pkg::set_idx_t init_set_o
);

    import cache_pkg::*;

    init_state_t state_q, state_d;
    set_idx_t    set_q, set_d;

    always_comb begin
        state_d = state_q;
        set_d   = set_q;
        case (state_q)
            INIT_SWEEP: begin
                set_d = set_q + 1'b1;
                // Last set cleared this cycle
                if (set_q == set_idx_t'(NUM_SETS - 1)) begin
                    state_d = INIT_DONE;
                end
            end
            default: begin
                state_d = INIT_DONE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= INIT_SWEEP;
            set_q   <= '0;
        end else begin
            state_q <= state_d;
            set_q   <= set_d;
        end
    end

    assign ready_o    = (state_q == INIT_DONE);
    assign init_set_o = set_q;

endmodule

// File: source/dir_array.sv
// ----------------------------
// Directory banks, access mux
// and tag compare
// ----------------------------
`timescale 1ns/1ps

module dir_array (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   ready_i,
    input  cache_pkg::set_idx_t    init_set_i,
    input  logic                   lookup_i,
    input  cache_pkg::lookup_req_t lookup_req_i,
    input  logic                   refill_i,
    input  cache_pkg::refill_req_t refill_req_i,
    output cache_pkg::way_vec_t    hit_way_o,
    output cache_pkg::way_vec_t    valid_ways_o,
    output logic                   rsp_valid_o
);

    import cache_pkg::*;

    localparam int unsigned DIR_W = $bits(dir_entry_t);

    set_idx_t   dir_addr;
    way_vec_t   dir_en;
    way_vec_t   dir_we;
    dir_entry_t dir_wentry;
    dir_entry_t [NUM_WAYS-1:0] dir_rentry;

    tag_t tag_q;
    logic rsp_valid_q;

    // Init sweep first, then lookup, then refill
    always_comb begin
        dir_addr   = '0;
        dir_en     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (!ready_i) begin
            dir_addr = init_set_i;
            dir_en   = '1;
            dir_we   = '1;
        end else if (lookup_i) begin
            dir_addr = lookup_req_i.set;
            dir_en   = '1;
        end else if (refill_i) begin
            dir_addr         = refill_req_i.set;
            dir_en           = refill_req_i.way;
            dir_we           = refill_req_i.way;
            dir_wentry.valid = 1'b1;
            dir_wentry.tag   = refill_req_i.tag;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_dir_bank
        sram_1rw #(
            .DEPTH   (NUM_SETS),
            .WIDTH   (DIR_W)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .en_i    (dir_en[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .be_i    ('1),
            .rdata_o (dir_rentry[w])
        );

        assign valid_ways_o[w] = dir_rentry[w].valid;
        assign hit_way_o[w]    = rsp_valid_q & dir_rentry[w].valid &
                                 (dir_rentry[w].tag == tag_q);
    end

    // Tag is compared one cycle later, against the bank output
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            tag_q <= lookup_req_i.tag;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= lookup_i & ready_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;

endmodule

// File: source/victim_sel.sv
// ----------------------------
// Pseudo-LRU bits and victim choice
// ----------------------------
`timescale 1ns/1ps

module victim_sel (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                lookup_i,
    input  cache_pkg::set_idx_t lookup_set_i,
    input  logic                updt_i,
    input  cache_pkg::set_idx_t updt_set_i,
    input  cache_pkg::way_vec_t updt_way_i,
    input  cache_pkg::way_vec_t valid_ways_i,
    output cache_pkg::way_vec_t victim_way_o
);

    import cache_pkg::*;

    way_vec_t plru_q [NUM_SETS];
    set_idx_t lookup_set_q;
    way_vec_t plru_next;
    way_vec_t plru_set;
    logic     found;

    // Set the used way, restart the round once every bit is set
    always_comb begin
        plru_next = plru_q[updt_set_i] | updt_way_i;
        if (&plru_next) begin
            plru_next = updt_way_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
            lookup_set_q <= '0;
        end else begin
            if (updt_i) begin
                plru_q[updt_set_i] <= plru_next;
            end
            if (lookup_i) begin
                lookup_set_q <= lookup_set_i;
            end
        end
    end

    // Invalid ways first, then the lowest clear PLRU bit
    always_comb begin
        plru_set     = plru_q[lookup_set_q];
        victim_way_o = '0;
        found        = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !valid_ways_i[w]) begin
                victim_way_o[w] = 1'b1;
                found           = 1'b1;
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !plru_set[w]) begin
                victim_way_o[w] = 1'b1;
                found           = 1'b1;
            end
        end
    end

endmodule

// File: source/data_array.sv
// ----------------------------
// Data banks, write merge, hit mux
// ----------------------------
`timescale 1ns/1ps

module data_array (
    input  logic                    clk_i,
    input  logic                    lookup_i,
    input  cache_pkg::lookup_req_t  lookup_req_i,
    input  logic                    write_i,
    input  cache_pkg::write_req_t   write_req_i,
    input  cache_pkg::way_vec_t     hit_way_i,
    input  logic                    refill_i,
    input  cache_pkg::refill_req_t  refill_req_i,
    output cache_pkg::data_word_t   rdata_o
);

    import cache_pkg::*;

    localparam int unsigned DEPTH = NUM_SETS * LINE_WORDS;

    logic [$clog2(DEPTH)-1:0] data_addr;
    way_vec_t   data_en;
    way_vec_t   data_we;
    data_word_t data_wdata;
    byte_en_t   data_be;
    data_word_t [NUM_WAYS-1:0] data_rword;

    always_comb begin
        data_addr  = '0;
        data_en    = '0;
        data_we    = '0;
        data_wdata = '0;
        data_be    = '0;
        if (refill_i) begin
            data_addr  = {refill_req_i.set, refill_req_i.word};
            data_en    = refill_req_i.way;
            data_we    = refill_req_i.way;
            data_wdata = refill_req_i.data;
            data_be    = '1;
        end else if (write_i) begin
            // Store goes to the way that hit one cycle earlier
            data_addr  = {write_req_i.set, write_req_i.word};
            data_en    = hit_way_i;
            data_we    = hit_way_i;
            data_wdata = write_req_i.data;
            data_be    = write_req_i.be;
        end else if (lookup_i) begin
            data_addr = {lookup_req_i.set, lookup_req_i.word};
            data_en   = '1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_data_bank
        sram_1rw #(
            .DEPTH   (DEPTH),
            .WIDTH   ($bits(data_word_t))
        ) u_data_ram (
            .clk_i   (clk_i),
            .en_i    (data_en[w]),
            .we_i    (data_we[w]),
            .addr_i  (data_addr),
            .wdata_i (data_wdata),
            .be_i    (data_be),
            .rdata_o (data_rword[w])
        );
    end

    // One-hot select that gives zero on a miss
    always_comb begin
        rdata_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way_i[w]) begin
                rdata_o = rdata_o | data_rword[w];
            end
        end
    end

endmodule

// File: source/cache_memctrl.sv
// ----------------------------
// Cache RAM controller top level
// ----------------------------
`timescale 1ns/1ps

module cache_memctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    output logic                   ready_o,
    input  logic                   lookup_i,
    input  cache_pkg::lookup_req_t lookup_req_i,
    input  logic                   write_i,
    input  cache_pkg::write_req_t  write_req_i,
    input  logic                   refill_i,
    input  cache_pkg::refill_req_t refill_req_i,
    output logic                   rsp_valid_o,
    output cache_pkg::lookup_rsp_t rsp_o
);

    import cache_pkg::*;

    logic       ready;
    logic       lookup_go;
    logic       write_go;
    logic       refill_go;
    set_idx_t   init_set;
    way_vec_t   hit_way;
    way_vec_t   valid_ways;
    way_vec_t   victim_way;
    data_word_t rdata;
    logic       rsp_valid;
    set_idx_t   rsp_set_q;
    logic       updt;
    set_idx_t   updt_set;
    way_vec_t   updt_way;

    // Strobes are dropped until the directory is cleared
    assign lookup_go = lookup_i & ready;
    assign write_go  = write_i & ready;
    assign refill_go = refill_i & ready;

    dir_init_fsm u_init (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ready_o    (ready),
        .init_set_o (init_set)
    );

    dir_array u_dir (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ready_i      (ready),
        .init_set_i   (init_set),
        .lookup_i     (lookup_go),
        .lookup_req_i (lookup_req_i),
        .refill_i     (refill_go),
        .refill_req_i (refill_req_i),
        .hit_way_o    (hit_way),
        .valid_ways_o (valid_ways),
        .rsp_valid_o  (rsp_valid)
    );

    data_array u_data (
        .clk_i        (clk_i),
        .lookup_i     (lookup_go),
        .lookup_req_i (lookup_req_i),
        .write_i      (write_go),
        .write_req_i  (write_req_i),
        .hit_way_i    (hit_way),
        .refill_i     (refill_go),
        .refill_req_i (refill_req_i),
        .rdata_o      (rdata)
    );

    // Set of the lookup now in its response cycle
    always_ff @(posedge clk_i) begin
        if (lookup_go) begin
            rsp_set_q <= lookup_req_i.set;
        end
    end

    // Refill beat wins over a hit in the same cycle
    assign updt     = refill_go | (|hit_way);
    assign updt_set = refill_go ? refill_req_i.set : rsp_set_q;
    assign updt_way = refill_go ? refill_req_i.way : hit_way;

    victim_sel u_victim (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_i     (lookup_go),
        .lookup_set_i (lookup_req_i.set),
        .updt_i       (updt),
        .updt_set_i   (updt_set),
        .updt_way_i   (updt_way),
        .valid_ways_i (valid_ways),
        .victim_way_o (victim_way)
    );

    always_comb begin
        rsp_o.hit        = |hit_way;
        rsp_o.hit_way    = hit_way;
        rsp_o.rdata      = rdata;
        rsp_o.victim_way = victim_way;
    end

    assign ready_o     = ready;
    assign rsp_valid_o = rsp_valid;

endmodule

// File: verification/cache_memctrl_asserts.sv
// ----------------------------
// Bound checks on strobes,
// response timing and ready
// ----------------------------
`timescale 1ns/1ps

module cache_memctrl_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic ready_i,
    input logic lookup_i,
    input logic write_i,
    input logic refill_i,
    input logic rsp_valid_i
);

    // At most one strobe per cycle
    strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({lookup_i, write_i, refill_i}))
        else $error("more than one access strobe high");

    rsp_after_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lookup_i && ready_i) |=> rsp_valid_i)
        else $error("accepted lookup without response");

    rsp_from_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i |-> $past(lookup_i && ready_i))
        else $error("response without accepted lookup");

    // Ready never drops once the sweep is done
    ready_stays: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_i |=> ready_i)
        else $error("ready fell after rising");

endmodule

bind cache_memctrl cache_memctrl_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ready_i     (ready_o),
    .lookup_i    (lookup_i),
    .write_i     (write_i),
    .refill_i    (refill_i),
    .rsp_valid_i (rsp_valid_o)
);

// File: verification/tb_cache_memctrl.sv
// ----------------------------
// Testbench for the cache RAM controller
// with reference model and directed tests
// ----------------------------
`timescale 1ns/1ps

module tb_cache_memctrl;

    import cache_pkg::*;

    // Tests need about 70 cycles in all
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RSP_WAIT       = 8;
    localparam int REFILL_SET     = 3;
    localparam int REFILL_WAY     = 2;
    localparam int PLRU_SET       = 9;

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        lookup;
    lookup_req_t lookup_req;
    logic        store;
    write_req_t  store_req;
    logic        refill;
    refill_req_t refill_req;
    logic        rsp_valid;
    lookup_rsp_t rsp;

    // Reference model of directory, data and PLRU bits
    logic       m_valid [NUM_SETS][NUM_WAYS];
    tag_t       m_tag   [NUM_SETS][NUM_WAYS];
    way_vec_t   m_plru  [NUM_SETS];
    data_word_t m_data  [NUM_SETS][NUM_WAYS][LINE_WORDS];

    logic [15:0] lfsr_q;
    string       cur_test;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycles;
    tag_t        line_tag;
    data_word_t  line_data [LINE_WORDS];

    cache_memctrl DUT (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .ready_o      (ready),
        .lookup_i     (lookup),
        .lookup_req_i (lookup_req),
        .write_i      (store),
        .write_req_i  (store_req),
        .refill_i     (refill),
        .refill_req_i (refill_req),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic way_vec_t plru_apply(input way_vec_t bits, input way_vec_t way);
        way_vec_t n;
        n = bits | way;
        if (n == '1) begin
            n = way;
        end
        return n;
    endfunction

    // Lowest invalid way, else lowest clear PLRU bit
    function automatic way_vec_t exp_victim(input set_idx_t set);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!m_valid[set][w]) begin
                return way_vec_t'(1 << w);
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!m_plru[set][w]) begin
                return way_vec_t'(1 << w);
            end
        end
        return '0;
    endfunction

    function automatic lookup_rsp_t exp_lookup(input lookup_req_t req);
        lookup_rsp_t r;
        r = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[req.set][w] && m_tag[req.set][w] == req.tag) begin
                r.hit        = 1'b1;
                r.hit_way[w] = 1'b1;
                r.rdata      = m_data[req.set][w][req.word];
            end
        end
        r.victim_way = exp_victim(req.set);
        return r;
    endfunction

    function automatic string fmt_rsp(input lookup_rsp_t r);
        return $sformatf("hit=%b way=%b data=%h victim=%b",
                         r.hit, r.hit_way, r.rdata, r.victim_way);
    endfunction

    task automatic check_rsp(input lookup_rsp_t exp, input lookup_rsp_t act);
        if (act !== exp) begin
            $display("** Error %s: response expected %s, actual %s",
                     cur_test, fmt_rsp(exp), fmt_rsp(act));
            test_errors++;
        end
    endtask

    task automatic check_word(input data_word_t exp, input data_word_t act);
        if (act !== exp) begin
            $display("** Error %s: word expected %h, actual %h", cur_test, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_ready(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: %s expected %b, actual %b", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("%s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // Stimulus tasks start and end on a falling edge
    task automatic refill_beat(input set_idx_t set, input int way, input tag_t tag,
                               input word_idx_t word, input data_word_t data);
        refill          = 1'b1;
        refill_req.set  = set;
        refill_req.way  = way_vec_t'(1 << way);
        refill_req.tag  = tag;
        refill_req.word = word;
        refill_req.data = data;
        @(negedge clk);
        refill                 = 1'b0;
        m_valid[set][way]      = 1'b1;
        m_tag[set][way]        = tag;
        m_data[set][way][word] = data;
        m_plru[set]            = plru_apply(m_plru[set], way_vec_t'(1 << way));
    endtask

    task automatic do_lookup(input set_idx_t set, input tag_t tag, input word_idx_t word,
                             output lookup_rsp_t got);
        lookup_req_t req;
        lookup_rsp_t exp;
        int          waited;
        req.set    = set;
        req.tag    = tag;
        req.word   = word;
        exp        = exp_lookup(req);
        lookup     = 1'b1;
        lookup_req = req;
        @(negedge clk);
        lookup = 1'b0;
        waited = 0;
        while (!rsp_valid && waited < RSP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        got = rsp;
        if (!rsp_valid) begin
            $display("%s: no lookup response within %0d cycles", cur_test, RSP_WAIT);
            test_errors++;
        end else begin
            // Response belongs in the cycle right after the strobe
            if (waited != 0) begin
                $display("%s: lookup response came %0d cycles late", cur_test, waited);
                test_errors++;
            end
            check_rsp(exp, got);
        end
        if (exp.hit) begin
            m_plru[set] = plru_apply(m_plru[set], exp.hit_way);
        end
        // Let the response cycle end before the next strobe
        @(negedge clk);
    endtask

    task automatic lookup_store(input set_idx_t set, input tag_t tag, input word_idx_t word,
                                input data_word_t data, input byte_en_t be);
        lookup_req_t req;
        lookup_rsp_t exp;
        req.set    = set;
        req.tag    = tag;
        req.word   = word;
        exp        = exp_lookup(req);
        lookup     = 1'b1;
        lookup_req = req;
        @(negedge clk);
        // Store goes out in the response cycle
        lookup         = 1'b0;
        store          = 1'b1;
        store_req.set  = set;
        store_req.word = word;
        store_req.data = data;
        store_req.be   = be;
        if (!rsp_valid) begin
            $display("%s: lookup response missing in the store cycle", cur_test);
            test_errors++;
        end else begin
            check_rsp(exp, rsp);
        end
        @(negedge clk);
        store = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (exp.hit_way[w]) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (be[b]) begin
                        m_data[set][w][word][8*b +: 8] = data[8*b +: 8];
                    end
                end
                m_plru[set] = plru_apply(m_plru[set], exp.hit_way);
            end
        end
    endtask

    task automatic test_ready_sweep();
        begin_test("ready_sweep");
        check_ready("ready in reset", 1'b0, ready);
        check_ready("rsp_valid in reset", 1'b0, rsp_valid);
        rst_n = 1'b1;
        // A lookup during the sweep is ignored
        lookup = 1'b1;
        for (int c = 0; c < NUM_SETS; c++) begin
            check_ready("ready during sweep", 1'b0, ready);
            check_ready("rsp_valid during sweep", 1'b0, rsp_valid);
            @(negedge clk);
        end
        lookup = 1'b0;
        check_ready("rsp_valid after sweep", 1'b0, rsp_valid);
        for (int c = 0; c < 4; c++) begin
            check_ready("ready after sweep", 1'b1, ready);
            @(negedge clk);
        end
        finish_test();
    endtask

    task automatic test_empty_miss();
        lookup_rsp_t exp;
        lookup_rsp_t got;
        begin_test("empty_miss");
        exp            = '0;
        exp.victim_way = way_vec_t'(1);
        for (int s = 5; s < 8; s++) begin
            do_lookup(set_idx_t'(s), tag_t'(rand_bits(TAG_BITS)), word_idx_t'(s), got);
            check_rsp(exp, got);
            check_word('0, got.rdata);
        end
        finish_test();
    endtask

    task automatic test_refill_line();
        lookup_rsp_t got;
        begin_test("refill_line");
        line_tag = tag_t'(rand_bits(TAG_BITS));
        for (int w = 0; w < LINE_WORDS; w++) begin
            line_data[w] = rand_bits(32);
            refill_beat(set_idx_t'(REFILL_SET), REFILL_WAY, line_tag, word_idx_t'(w),
                        line_data[w]);
        end
        for (int w = 0; w < LINE_WORDS; w++) begin
            do_lookup(set_idx_t'(REFILL_SET), line_tag, word_idx_t'(w), got);
            check_word(line_data[w], got.rdata);
            check_ready("hit", 1'b1, got.hit);
        end
        finish_test();
    endtask

    task automatic test_store_merge();
        data_word_t  new_data;
        data_word_t  merged;
        byte_en_t    be;
        lookup_rsp_t got;
        begin_test("store_merge");
        new_data = rand_bits(32);
        be       = 4'b0101;
        for (int b = 0; b < WORD_BYTES; b++) begin
            merged[8*b +: 8] = be[b] ? new_data[8*b +: 8] : line_data[1][8*b +: 8];
        end
        lookup_store(set_idx_t'(REFILL_SET), line_tag, word_idx_t'(1), new_data, be);
        do_lookup(set_idx_t'(REFILL_SET), line_tag, word_idx_t'(1), got);
        check_word(merged, got.rdata);
        // Neighbour word untouched
        do_lookup(set_idx_t'(REFILL_SET), line_tag, word_idx_t'(2), got);
        check_word(line_data[2], got.rdata);
        finish_test();
    endtask

    task automatic test_plru_victim();
        int          order [6] = '{1, 0, 2, 3, 3, 1};
        tag_t        base;
        lookup_rsp_t got;
        begin_test("plru_victim");
        base = tag_t'(rand_bits(TAG_BITS));
        for (int w = 0; w < NUM_WAYS; w++) begin
            refill_beat(set_idx_t'(PLRU_SET), w, base + tag_t'(w), '0, rand_bits(32));
        end
        for (int i = 0; i < 6; i++) begin
            do_lookup(set_idx_t'(PLRU_SET), base + tag_t'(order[i]), '0, got);
        end
        // Tags not in the set
        for (int i = 0; i < 2; i++) begin
            do_lookup(set_idx_t'(PLRU_SET), base + tag_t'(NUM_WAYS + i), '0, got);
            check_ready("hit on foreign tag", 1'b0, got.hit);
        end
        finish_test();
    endtask

    initial begin
        lfsr_q       = 16'd75;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        lookup       = 1'b0;
        lookup_req   = '0;
        store        = 1'b0;
        store_req    = '0;
        refill       = 1'b0;
        refill_req   = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (2) @(negedge clk);
        test_ready_sweep();
        test_empty_miss();
        test_refill_line();
        test_store_merge();
        test_plru_victim();
        $display("%0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles while running %s", cycles, cur_test);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: files.f
source/cache_pkg.sv
source/sram_1rw.sv
source/dir_init_fsm.sv
source/dir_array.sv
source/victim_sel.sv
source/data_array.sv
source/cache_memctrl.sv
verification/cache_memctrl_asserts.sv
verification/tb_cache_memctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the cache controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_cache_memctrl -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
